/* toom4_mul.f */
+incdir+tests
design/toom4_pkg.sv
design/toom4_eval.sv
design/clmul_seq.sv
design/exact_div.sv
design/toom4_core.sv
design/toom4_wb_regs.sv
design/toom4_top.sv
tests/toom4_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = toom4_tb
FILELIST  = toom4_mul.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) tests/toom4_tb_bus.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* tests/toom4_tb_bus.svh */
`ifndef TOOM4_TB_BUS_SVH
`define TOOM4_TB_BUS_SVH

////////////////////
// wishbone classic master

task automatic write_word(input logic [WB_ADR_W-1:0] addr, input logic [WB_DATA_W-1:0] data);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= 1'b1;
    adr   <= addr;
    dat_w <= data;
    @(posedge clk);
    while (!ack) @(posedge clk);   // ack as it stood before this edge
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
endtask

task automatic read_word(input logic [WB_ADR_W-1:0] addr, output logic [WB_DATA_W-1:0] data);
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= addr;
    @(posedge clk);
    while (!ack) @(posedge clk);
    data = dat_r;   // captured on the edge that raised ack
    cyc <= 1'b0;
    stb <= 1'b0;
endtask

task automatic write_operand(input logic [WB_ADR_W-1:0] base, input logic [OP_W-1:0] value);
    for (int k = 0; k < OP_WORDS; k++) begin
        write_word(base + WB_ADR_W'(k), value[k*WB_DATA_W +: WB_DATA_W]);
    end
endtask

task automatic read_block(input logic [WB_ADR_W-1:0] base, input int words,
                          output logic [RES_W-1:0] value);
    logic [WB_DATA_W-1:0] word;
    value = '0;
    for (int k = 0; k < words; k++) begin
        read_word(base + WB_ADR_W'(k), word);
        value[k*WB_DATA_W +: WB_DATA_W] = word;
    end
endtask

// xorshift32, shifts 13/17/5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

`endif

/* tests/toom4_tb.sv */
`timescale 1ns/1ps

module toom4_tb;
    import toom4_pkg::*;

    localparam int LIMB_W     = 16;
    localparam int OP_W       = 4 * LIMB_W;
    localparam int RES_W      = 8 * LIMB_W;
    localparam int EVAL_W     = LIMB_W + 3;
    localparam int PROD_W     = 2 * EVAL_W - 1;
    localparam int OP_WORDS   = OP_W / WB_DATA_W;
    localparam int RES_WORDS  = RES_W / WB_DATA_W;
    localparam int NUM_FIXED  = 10;
    localparam int NUM_RAND   = 6;
    localparam int NUM_ROWS   = NUM_FIXED + NUM_RAND;
    localparam int ROW_CYCLES = 7 * (EVAL_W + 3) + 4 * (PROD_W + 2) + 64;
    localparam int TIMEOUT    = (NUM_ROWS + 4) * ROW_CYCLES;   // directed cases count as rows

    logic                 clk;
    logic                 reset;
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [WB_ADR_W-1:0]  adr;
    logic [WB_DATA_W-1:0] dat_w;
    logic [3:0]           sel;
    logic [WB_DATA_W-1:0] dat_r;
    logic                 ack;

    logic [OP_W-1:0]  tab_u [NUM_ROWS];
    logic [OP_W-1:0]  tab_v [NUM_ROWS];
    logic [RES_W-1:0] tab_w [NUM_ROWS];
    int               cycles = 0;

    `include "toom4_tb_bus.svh"

    toom4_top #(.LIMB_W(LIMB_W)) toom4_top_i (
        .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("run timed out after %0d cycles without finishing", cycles);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [RES_W-1:0] got,
                               input logic [RES_W-1:0] exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // carry-less product built one bit of b at a time
    function automatic logic [RES_W-1:0] clmul_ref(input logic [OP_W-1:0] a,
                                                   input logic [OP_W-1:0] b);
        logic [RES_W-1:0] acc;
        acc = '0;
        for (int i = 0; i < OP_W; i++) begin
            if (b[i]) acc = acc ^ (RES_W'(a) << i);
        end
        return acc;
    endfunction

    task automatic build_table();
        logic [31:0] rng;
        rng = 32'hde90;
        tab_u[0] = '0;
        tab_v[0] = 64'h0123_4567_89ab_cdef;
        tab_u[1] = '1;
        tab_v[1] = '1;
        tab_u[2] = 64'h1;
        tab_v[2] = 64'h1 << 63;
        tab_u[3] = 64'h1 << 15;
        tab_v[3] = 64'h1 << 16;
        tab_u[4] = 64'h1 << 31;
        tab_v[4] = 64'h1 << 32;
        tab_u[5] = 64'h1 << 47;
        tab_v[5] = 64'h1 << 48;
        tab_u[6] = 64'h1 << 63;
        tab_v[6] = 64'h1 << 63;
        tab_u[7] = 64'h5555_5555_5555_5555;
        tab_v[7] = 64'haaaa_aaaa_aaaa_aaaa;
        tab_u[8] = 64'haaaa_aaaa_aaaa_aaaa;
        tab_v[8] = '1;
        tab_u[9] = 64'hffff_0000_ffff_0000;
        tab_v[9] = 64'h0000_ffff_0000_ffff;
        for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
            rng = xorshift32(rng);
            tab_u[i][31:0] = rng;
            rng = xorshift32(rng);
            tab_u[i][63:32] = rng;
            rng = xorshift32(rng);
            tab_v[i][31:0] = rng;
            rng = xorshift32(rng);
            tab_v[i][63:32] = rng;
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            tab_w[i] = clmul_ref(tab_u[i], tab_v[i]);
        end
    endtask

    // busy with done clear until the end and done alone after it
    task automatic wait_done();
        logic [WB_DATA_W-1:0] st;
        read_word(REG_STATUS, st);
        check_value("status", RES_W'(st), RES_W'(32'h1));
        while (st[0]) begin
            read_word(REG_STATUS, st);
            if (st[0]) check_value("status", RES_W'(st), RES_W'(32'h1));
        end
        check_value("status", RES_W'(st), RES_W'(32'h2));
    endtask

    task automatic read_unmapped(input logic [WB_ADR_W-1:0] addr);
        logic [WB_DATA_W-1:0] word;
        read_word(addr, word);
        check_value("dat_r", RES_W'(word), '0);
    endtask

    initial begin
        logic [RES_W-1:0]     res;
        logic [WB_DATA_W-1:0] st;
        logic [RES_W-1:0]     expect_w;
        reset = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        sel   = 4'hf;   // full words only
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        ////////////////////
        // state after reset
        read_word(REG_STATUS, st);
        check_value("status", RES_W'(st), '0);
        read_block(REG_W_BASE, RES_WORDS, res);
        check_value("w", res, '0);
        read_block(REG_U_BASE, OP_WORDS, res);
        check_value("u", res, '0);
        read_block(REG_V_BASE, OP_WORDS, res);
        check_value("v", res, '0);

        build_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            write_operand(REG_U_BASE, tab_u[i]);
            write_operand(REG_V_BASE, tab_v[i]);
            write_word(REG_CTRL, 32'h1);
            wait_done();
            read_block(REG_W_BASE, RES_WORDS, res);
            check_value("w", res, tab_w[i]);
        end

        ////////////////////
        // second start while busy is dropped
        write_operand(REG_U_BASE, tab_u[1]);
        write_operand(REG_V_BASE, tab_v[1]);
        write_word(REG_CTRL, 32'h1);
        write_word(REG_CTRL, 32'h1);
        wait_done();
        read_word(REG_STATUS, st);
        check_value("status", RES_W'(st), RES_W'(32'h2));   // no restart
        read_block(REG_W_BASE, RES_WORDS, res);
        check_value("w", res, tab_w[1]);

        // new v only and the result holds until start
        write_operand(REG_V_BASE, tab_v[7]);
        read_block(REG_W_BASE, RES_WORDS, res);
        check_value("w", res, tab_w[1]);
        write_word(REG_CTRL, 32'h1);
        wait_done();
        expect_w = clmul_ref(tab_u[1], tab_v[7]);
        read_block(REG_W_BASE, RES_WORDS, res);
        check_value("w", res, expect_w);

        ////////////////////
        // unmapped addresses
        read_unmapped(6'd2);
        read_unmapped(6'd12);
        read_unmapped(6'd20);
        read_unmapped(6'd30);
        read_unmapped(6'd63);
        write_word(6'd2, 32'hc3c3_5a5a);
        write_word(6'd20, 32'h0000_0001);
        write_word(6'd28, 32'h1234_5678);
        read_unmapped(6'd20);
        read_block(REG_U_BASE, OP_WORDS, res);
        check_value("u", res, RES_W'(tab_u[1]));
        read_block(REG_V_BASE, OP_WORDS, res);
        check_value("v", res, RES_W'(tab_v[7]));
        read_word(REG_STATUS, st);
        check_value("status", RES_W'(st), RES_W'(32'h2));
        read_block(REG_W_BASE, RES_WORDS, res);
        check_value("w", res, expect_w);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* design/toom4_top.sv */
`timescale 1ns/1ps

module toom4_top #(
    parameter int LIMB_W = 16
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cyc,
    input  logic                           stb,
    input  logic                           we,
    input  logic [toom4_pkg::WB_ADR_W-1:0]  adr,
    input  logic [toom4_pkg::WB_DATA_W-1:0] dat_w,
    input  logic [3:0]                     sel,
    output logic [toom4_pkg::WB_DATA_W-1:0] dat_r,
    output logic                           ack
);

    logic [4*LIMB_W-1:0] u;
    logic [4*LIMB_W-1:0] v;
    logic                start;
    logic                busy;
    logic                done;
    logic [8*LIMB_W-1:0] w;

    toom4_wb_regs #(.LIMB_W(LIMB_W)) wb_regs_i (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .sel   (sel),
        .dat_r (dat_r),
        .ack   (ack),
        .u     (u),
        .v     (v),
        .start (start),
        .busy  (busy),
        .done  (done),
        .w     (w)
    );

    toom4_core #(.LIMB_W(LIMB_W)) core_i (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .u     (u),
        .v     (v),
        .busy  (busy),
        .done  (done),
        .w     (w)
    );

endmodule

/* design/toom4_wb_regs.sv */
`timescale 1ns/1ps

module toom4_wb_regs #(
    parameter int LIMB_W = 16
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           cyc,
    input  logic                           stb,
    input  logic                           we,
    input  logic [toom4_pkg::WB_ADR_W-1:0]  adr,
    input  logic [toom4_pkg::WB_DATA_W-1:0] dat_w,
    input  logic [3:0]                     sel,
    output logic [toom4_pkg::WB_DATA_W-1:0] dat_r,
    output logic                           ack,
    output logic [4*LIMB_W-1:0]            u,
    output logic [4*LIMB_W-1:0]            v,
    output logic                           start,
    input  logic                           busy,
    input  logic                           done,
    input  logic [8*LIMB_W-1:0]            w
);
    import toom4_pkg::*;

    localparam int OP_W      = 4 * LIMB_W;
    localparam int RES_W     = 8 * LIMB_W;
    localparam int OP_WORDS  = (OP_W + WB_DATA_W - 1) / WB_DATA_W;
    localparam int RES_WORDS = (RES_W + WB_DATA_W - 1) / WB_DATA_W;

    logic [OP_WORDS*WB_DATA_W-1:0]  u_reg;
    logic [OP_WORDS*WB_DATA_W-1:0]  v_reg;
    logic [RES_WORDS*WB_DATA_W-1:0] w_pad;
    logic [WB_DATA_W-1:0]           rd_word;
    logic                           req;
    logic                           u_hit;
    logic                           v_hit;
    logic                           w_hit;

    // blocks are 8 words wide and 8-word aligned
    function automatic logic in_block(logic [WB_ADR_W-1:0] a, logic [WB_ADR_W-1:0] base,
                                      int unsigned words);
        return (a[WB_ADR_W-1:3] == base[WB_ADR_W-1:3]) && (int'(a[2:0]) < words);
    endfunction

    assign req   = cyc && stb && !ack;   // new request, ack one edge later
    assign u_hit = in_block(adr, REG_U_BASE, OP_WORDS);
    assign v_hit = in_block(adr, REG_V_BASE, OP_WORDS);
    assign w_hit = in_block(adr, REG_W_BASE, RES_WORDS);

    assign u     = u_reg[OP_W-1:0];
    assign v     = v_reg[OP_W-1:0];
    assign w_pad = (RES_WORDS * WB_DATA_W)'(w);

    always_ff @(posedge clk) begin
        if (reset) begin
            ack   <= 1'b0;
            start <= 1'b0;
            u_reg <= '0;
            v_reg <= '0;
        end else begin
            ack   <= req;
            // start request dropped while the core runs
            start <= req && we && (adr == REG_CTRL) && dat_w[0] && !busy && !start;
            if (req && we && u_hit) begin
                u_reg[adr[2:0]*WB_DATA_W +: WB_DATA_W] <= dat_w;
            end
            if (req && we && v_hit) begin
                v_reg[adr[2:0]*WB_DATA_W +: WB_DATA_W] <= dat_w;
            end
        end
    end

    ////////////////////
    // read path

    always_comb begin
        rd_word = '0;   // unmapped reads as zero
        if (u_hit) begin
            rd_word = u_reg[adr[2:0]*WB_DATA_W +: WB_DATA_W];
        end else if (v_hit) begin
            rd_word = v_reg[adr[2:0]*WB_DATA_W +: WB_DATA_W];
        end else if (w_hit) begin
            rd_word = w_pad[adr[2:0]*WB_DATA_W +: WB_DATA_W];
        end else if (adr == REG_STATUS) begin
            rd_word = WB_DATA_W'({done, busy});
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            dat_r <= rd_word;   // valid while ack is high
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack);

    // byte lanes are not decoded, so writes must be full words
    a_full_word: assert property (@(posedge clk) disable iff (reset)
        cyc && stb && we |-> sel == 4'hf);

endmodule

/* design/toom4_core.sv */
`timescale 1ns/1ps

module toom4_core #(
    parameter int LIMB_W = 16
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic [4*LIMB_W-1:0] u,
    input  logic [4*LIMB_W-1:0] v,
    output logic                busy,
    output logic                done,
    output logic [8*LIMB_W-1:0] w
);
    import toom4_pkg::*;

    localparam int EVAL_W = LIMB_W + 3;
    localparam int PROD_W = 2 * EVAL_W - 1;
    localparam int RES_W  = 8 * LIMB_W;
    localparam int CO_W   = 2 * LIMB_W - 1;   // true width of w0..w6

    core_step_t        step;
    eval_point_t       point;
    logic [PROD_W-1:0] wr [NUM_POINTS];
    logic [EVAL_W-1:0] u_val;
    logic [EVAL_W-1:0] v_val;
    logic [PROD_W-1:0] prod;
    logic              mul_start;
    logic              mul_done;
    logic [PROD_W-1:0] div1_in;
    logic [PROD_W-1:0] div1_q;
    logic              div1_start;
    logic              div1_done;
    logic [PROD_W-1:0] div2_in;
    logic [PROD_W-1:0] div2_q;
    logic              div2_start;
    logic              div2_done;
    logic [RES_W-1:0]  combo;

    // slots chosen so each coefficient ends in wr[k]
    function automatic int unsigned slot(eval_point_t pt);
        case (pt)
            PT_0:    return 0;
            PT_X1:   return 1;
            PT_X:    return 2;
            PT_1:    return 3;
            PT_IX:   return 4;
            PT_IX1:  return 5;
            default: return 6;
        endcase
    endfunction

    // products by (x+1)^3, (x+1)^5, (x+1)^6
    function automatic logic [PROD_W-1:0] mul_s3(logic [PROD_W-1:0] a);
        return a ^ (a << 1) ^ (a << 2) ^ (a << 3);
    endfunction

    function automatic logic [PROD_W-1:0] mul_s5(logic [PROD_W-1:0] a);
        return a ^ (a << 1) ^ (a << 4) ^ (a << 5);
    endfunction

    function automatic logic [PROD_W-1:0] mul_s6(logic [PROD_W-1:0] a);
        return a ^ (a << 2) ^ (a << 4) ^ (a << 6);
    endfunction

    assign busy       = (step != ST_IDLE);
    assign mul_start  = (step == ST_MUL_GO);
    assign div1_start = (step == ST_DIV_P) || (step == ST_DIV_M);
    assign div2_start = (step == ST_DIV_Q) || (step == ST_DIV_N);
    assign div1_in    = (step == ST_DIV_P) ? wr[5] : wr[1];
    assign div2_in    = (step == ST_DIV_Q) ? wr[4] ^ (wr[5] << 5) ^ (wr[5] << 1)
                                           : wr[2] ^ (wr[1] << 5) ^ (wr[1] << 1);

    toom4_eval #(.LIMB_W(LIMB_W)) eval_u_i (
        .clk(clk), .load(step == ST_LOAD), .point(point), .limbs(u), .value(u_val)
    );

    toom4_eval #(.LIMB_W(LIMB_W)) eval_v_i (
        .clk(clk), .load(step == ST_LOAD), .point(point), .limbs(v), .value(v_val)
    );

    clmul_seq #(.W_IN(EVAL_W)) mul_i (
        .clk(clk), .reset(reset), .start(mul_start),
        .a(u_val), .b(v_val), .p(prod), .done(mul_done)
    );

    exact_div #(.W(PROD_W), .DIVISOR('h12)) div_x_i (          // x^4 + x
        .clk(clk), .reset(reset), .start(div1_start),
        .dividend(div1_in), .quotient(div1_q), .done(div1_done)
    );

    exact_div #(.W(PROD_W), .DIVISOR('h14)) div_x2_i (         // x^4 + x^2
        .clk(clk), .reset(reset), .start(div2_start),
        .dividend(div2_in), .quotient(div2_q), .done(div2_done)
    );

    ////////////////////
    // sequencer

    always_ff @(posedge clk) begin
        if (reset) begin
            step  <= ST_IDLE;
            point <= PT_0;
            done  <= 1'b0;
            w     <= '0;
        end else begin
            case (step)
                ST_IDLE: begin
                    if (start) begin
                        step  <= ST_LOAD;
                        point <= PT_0;
                        done  <= 1'b0;
                    end
                end
                ST_MUL_WAIT: begin
                    if (mul_done && point == PT_INF) begin
                        step <= ST_FIX_A;
                    end else if (mul_done) begin
                        point <= eval_point_t'(point + 3'd1);
                        step  <= ST_LOAD;
                    end
                end
                ST_WAIT_P: if (div1_done) step <= ST_DIV_Q;
                ST_WAIT_Q: if (div2_done) step <= ST_W3;
                ST_WAIT_M: if (div1_done) step <= ST_DIV_N;
                ST_WAIT_N: if (div2_done) step <= ST_W4;
                ST_COMBINE: begin
                    w    <= combo;
                    done <= 1'b1;
                    step <= ST_IDLE;
                end
                default: step <= core_step_t'(step + 5'd1);   // straight-line step
            endcase
        end
    end

    ////////////////////
    // products and interpolation

    // A,B,C,D,E are the point values with w0 and w6 removed
    always_ff @(posedge clk) begin
        case (step)
            ST_MUL_WAIT: if (mul_done) wr[slot(point)] <= prod;
            ST_FIX_A:  wr[3] <= wr[3] ^ wr[0] ^ wr[6];
            ST_FIX_B:  wr[2] <= wr[2] ^ wr[0] ^ (wr[6] << 6);
            ST_FIX_C:  wr[4] <= wr[4] ^ (wr[0] << 6) ^ wr[6];
            ST_FIX_D:  wr[1] <= wr[1] ^ wr[0] ^ mul_s6(wr[6]);
            ST_FIX_E:  wr[5] <= wr[5] ^ mul_s6(wr[0]) ^ wr[6];
            ST_BC:     wr[4] <= wr[4] ^ wr[2];                 // B+C
            ST_BCDE:   wr[5] <= wr[5] ^ wr[1] ^ wr[4];         // B+C+D+E
            ST_WAIT_P: if (div1_done) wr[5] <= div1_q;         // p = w1+w5
            ST_WAIT_Q: if (div2_done) wr[4] <= div2_q;         // q = w2+w4
            ST_W3:     wr[3] <= wr[3] ^ wr[4] ^ wr[5];
            ST_BP:     wr[2] <= wr[2] ^ (wr[3] << 3) ^ (wr[4] << 4) ^ (wr[5] << 5);
            ST_DP: begin
                // D' folded onto B'
                wr[1] <= wr[1] ^ wr[2] ^ mul_s3(wr[3]) ^ wr[4] ^ (wr[4] << 4)
                         ^ mul_s5(wr[5]);
            end
            ST_WAIT_M: if (div1_done) wr[1] <= div1_q;
            ST_WAIT_N: if (div2_done) wr[2] <= div2_q;
            ST_W4:     wr[4] <= wr[4] ^ wr[2];
            ST_W5:     wr[5] <= wr[5] ^ wr[1];
            default: ;
        endcase
    end

    // overlap the coefficients at limb offsets
    always_comb begin
        combo = '0;
        for (int k = 0; k < NUM_POINTS; k++) begin
            combo = combo ^ (RES_W'(wr[k][CO_W-1:0]) << (k * LIMB_W));
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

/* design/exact_div.sv */
`timescale 1ns/1ps

module exact_div #(
    parameter int W       = 37,
    parameter int DIVISOR = 'h12
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    input  logic [W-1:0] dividend,
    output logic [W-1:0] quotient,
    output logic         done
);

    // lowest set bit of the divisor
    function automatic int low_bit(int d);
        int pos;
        pos = 0;
        for (int i = 31; i >= 0; i--) begin
            if (d[i]) pos = i;
        end
        return pos;
    endfunction

    localparam int LOW   = low_bit(DIVISOR);
    localparam int CNT_W = $clog2(W + 1);

    logic [W-1:0]     rem;
    logic [W-1:0]     rem_sh;
    logic [W-1:0]     div_sh;
    logic [CNT_W-1:0] cnt;
    logic             running;

    assign rem_sh = rem >> cnt;             // bit LOW is the term to cancel
    assign div_sh = W'(DIVISOR) << cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            done    <= 1'b0;
            cnt     <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(W - 1)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem      <= dividend;
            quotient <= '0;
        end else if (running) begin
            if (rem_sh[LOW]) begin
                rem <= rem ^ div_sh;
            end
            quotient <= {rem_sh[LOW], quotient[W-1:1]};   // low coefficient first
        end
    end

    a_exact: assert property (@(posedge clk) disable iff (reset) done |-> rem == '0);

endmodule

/* design/clmul_seq.sv */
`timescale 1ns/1ps

module clmul_seq #(
    parameter int W_IN = 19
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic [W_IN-1:0]   a,
    input  logic [W_IN-1:0]   b,
    output logic [2*W_IN-2:0] p,
    output logic              done
);

    localparam int P_W   = 2 * W_IN - 1;
    localparam int CNT_W = $clog2(W_IN + 1);

    logic [P_W-1:0]   a_sh;
    logic [W_IN-1:0]  b_sh;
    logic [CNT_W-1:0] cnt;
    logic             running;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            done    <= 1'b0;
            cnt     <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(W_IN - 1)) begin
                    running <= 1'b0;
                    done    <= 1'b1;   // product final on this edge
                end
            end
        end
    end

    // one bit of b per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            a_sh <= P_W'(a);
            b_sh <= b;
            p    <= '0;
        end else if (running) begin
            if (b_sh[0]) begin
                p <= p ^ a_sh;
            end
            a_sh <= a_sh << 1;
            b_sh <= b_sh >> 1;
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (reset) start |-> !running);

endmodule

/* design/toom4_eval.sv */
`timescale 1ns/1ps

module toom4_eval #(
    parameter int LIMB_W = 16
) (
    input  logic                   clk,
    input  logic                   load,
    input  toom4_pkg::eval_point_t point,
    input  logic [4*LIMB_W-1:0]    limbs,
    output logic [LIMB_W+2:0]      value
);
    import toom4_pkg::*;

    localparam int EVAL_W = LIMB_W + 3;

    logic [LIMB_W-1:0] l0, l1, l2, l3;
    logic [EVAL_W-1:0] c0, c1, c2, c3;
    logic [EVAL_W-1:0] at_x;
    logic [EVAL_W-1:0] at_x1;
    logic [EVAL_W-1:0] ev;
    logic              recip;

    assign {l3, l2, l1, l0} = limbs;
    assign recip = (point == PT_IX) || (point == PT_IX1);

    // reciprocal points use the reversed limb order
    assign c0 = EVAL_W'(recip ? l3 : l0);
    assign c1 = EVAL_W'(recip ? l2 : l1);
    assign c2 = EVAL_W'(recip ? l1 : l2);
    assign c3 = EVAL_W'(recip ? l0 : l3);

    assign at_x  = c0 ^ (c1 << 1) ^ (c2 << 2) ^ (c3 << 3);
    assign at_x1 = c0 ^ c1 ^ (c1 << 1)                      // (x+1)
                 ^ c2 ^ (c2 << 2)                           // (x+1)^2
                 ^ c3 ^ (c3 << 1) ^ (c3 << 2) ^ (c3 << 3);  // (x+1)^3

    always_comb begin
        case (point)
            PT_0:          ev = c0;
            PT_1:          ev = c0 ^ c1 ^ c2 ^ c3;
            PT_X, PT_IX:   ev = at_x;
            PT_X1, PT_IX1: ev = at_x1;
            default:       ev = c3;   // infinity, top limb
        endcase
    end

    always_ff @(posedge clk) begin
        if (load) begin
            value <= ev;
        end
    end

endmodule

/* design/toom4_pkg.sv */
package toom4_pkg;

    ////////////////////
    // wishbone side

    localparam int WB_DATA_W = 32;
    localparam int WB_ADR_W  = 6;     // word address

    localparam logic [WB_ADR_W-1:0] REG_U_BASE = 6'd0;    // words 0..7
    localparam logic [WB_ADR_W-1:0] REG_V_BASE = 6'd8;    // words 8..15
    localparam logic [WB_ADR_W-1:0] REG_CTRL   = 6'd16;   // bit 0 requests a start
    localparam logic [WB_ADR_W-1:0] REG_STATUS = 6'd17;   // bit 0 busy, bit 1 done
    localparam logic [WB_ADR_W-1:0] REG_W_BASE = 6'd24;   // words 24..31

    ////////////////////
    // toom-cook core

    localparam int NUM_POINTS = 7;

    // 1/x and 1/(x+1) are scaled by x^3 and (x+1)^3
    typedef enum logic [2:0] {
        PT_0,
        PT_1,
        PT_X,
        PT_X1,
        PT_IX,
        PT_IX1,
        PT_INF
    } eval_point_t;

    // straight-line steps follow each other in this order
    typedef enum logic [4:0] {
        ST_IDLE,
        ST_LOAD,
        ST_MUL_GO,
        ST_MUL_WAIT,
        ST_FIX_A,
        ST_FIX_B,
        ST_FIX_C,
        ST_FIX_D,
        ST_FIX_E,
        ST_BC,
        ST_BCDE,
        ST_DIV_P,
        ST_WAIT_P,
        ST_DIV_Q,
        ST_WAIT_Q,
        ST_W3,
        ST_BP,
        ST_DP,
        ST_DIV_M,
        ST_WAIT_M,
        ST_DIV_N,
        ST_WAIT_N,
        ST_W4,
        ST_W5,
        ST_COMBINE
    } core_step_t;

endpackage
